// File: controller_multicycle.sv
module controller_multicycle import riscv_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        hold,       // test mode, freeze everything
    input  logic [31:0] instr,
    input  logic [3:0]  alu_flags,  // {zero, negative, carry, overflow}
    output ctrl_t       ctrl
);
    typedef enum logic [3:0] {
        S_FETCH, S_DECODE, S_EXEC, S_ALU_WB, S_ADDR, S_READ,
        S_MEM_WB, S_WRITE, S_BRANCH, S_JUMP, S_HALT
    } state_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    state_e     state_q, state_d;
    ctrl_t      ctrl_s;         // state outputs before the hold mask
    logic [6:0] opcode;
    logic [2:0] funct3;
    alu_op_e    alu_fn;
    mem_dt_e    dt_dec;
    logic       taken;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign dt_dec = (funct3[1:0] == 2'b10) ? MEM_DT_WORD : MEM_DT_BYTE; // lw/sw vs lbu/sb
    assign taken  = alu_flags[3] ^ funct3[0];   // beq on zero, bne otherwise

    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
            3'b010:  alu_fn = ALU_SLT;
            3'b100:  alu_fn = ALU_XOR;
            3'b110:  alu_fn = ALU_OR;
            3'b111:  alu_fn = ALU_AND;
            default: alu_fn = ALU_ADD;
        endcase
        if (opcode == OPC_LUI) alu_fn = ALU_PASS_B; // funct3 field is imm there
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FETCH:  state_d = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OPC_OP, OPC_OP_IMM, OPC_LUI: state_d = S_EXEC;
                    OPC_LOAD, OPC_STORE:         state_d = S_ADDR;
                    OPC_BRANCH:                  state_d = S_BRANCH;
                    OPC_JAL:                     state_d = S_JUMP;
                    default:                     state_d = S_HALT; // stuck until reset
                endcase
            end
            S_EXEC:   state_d = S_ALU_WB;
            S_ADDR:   state_d = (opcode == OPC_LOAD) ? S_READ : S_WRITE;
            S_READ:   state_d = S_MEM_WB;
            S_HALT:   state_d = S_HALT;
            default:  state_d = S_FETCH;   // wb, write, branch, jump
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_FETCH;
        end else if (!hold) begin
            state_q <= state_d;
        end
    end

    // consumer states repeat their producer's alu setup so alu_out survives a hold
    always_comb begin
        ctrl_s           = '0;
        ctrl_s.alu_src_a = ALU_SRC_REG;
        ctrl_s.alu_src_b = ALU_SRC_REG;
        ctrl_s.alu_op    = ALU_ADD;
        ctrl_s.imm_src   = IMM_I;
        ctrl_s.res_src   = RES_ALU;
        ctrl_s.dt        = MEM_DT_WORD;
        case (state_q)
            S_FETCH: begin
                ctrl_s.alu_src_a = ALU_SRC_PC;   // pc + 4
                ctrl_s.alu_src_b = ALU_SRC_FOUR;
                ctrl_s.en_ir     = 1'b1;
                ctrl_s.en_npc    = 1'b1;
            end
            S_DECODE: begin
                ctrl_s.alu_src_a = ALU_SRC_OLD_PC; // speculative target
                ctrl_s.alu_src_b = ALU_SRC_IMM;
                ctrl_s.imm_src   = (opcode == OPC_JAL) ? IMM_J : IMM_B;
            end
            S_EXEC, S_ALU_WB: begin
                ctrl_s.alu_src_b = (opcode == OPC_OP) ? ALU_SRC_REG : ALU_SRC_IMM;
                ctrl_s.imm_src   = (opcode == OPC_LUI) ? IMM_U : IMM_I;
                ctrl_s.alu_op    = alu_fn;
                ctrl_s.res_src   = RES_ALU_OUT;
                ctrl_s.reg_we    = (state_q == S_ALU_WB);
            end
            S_ADDR, S_READ, S_WRITE: begin
                ctrl_s.alu_src_b  = ALU_SRC_IMM;    // rs1 + offset
                ctrl_s.imm_src    = (opcode == OPC_STORE) ? IMM_S : IMM_I;
                ctrl_s.dt         = dt_dec;
                ctrl_s.m_addr_src = (state_q != S_ADDR);
                ctrl_s.mem_we     = (state_q == S_WRITE);
            end
            S_MEM_WB: begin
                ctrl_s.res_src = RES_MEM;
                ctrl_s.reg_we  = 1'b1;
            end
            S_BRANCH: begin
                ctrl_s.alu_op     = ALU_SUB;        // rs1 - rs2 for the zero flag
                ctrl_s.m_addr_src = 1'b1;           // target already in alu_out
                ctrl_s.en_npc     = taken;
            end
            S_JUMP: begin
                ctrl_s.alu_src_a  = ALU_SRC_OLD_PC; // link value
                ctrl_s.alu_src_b  = ALU_SRC_FOUR;
                ctrl_s.m_addr_src = 1'b1;
                ctrl_s.reg_we     = 1'b1;
                ctrl_s.en_npc     = 1'b1;
            end
            default: ;                              // halt, all quiet
        endcase
    end

    always_comb begin
        ctrl = ctrl_s;
        if (hold) begin
            ctrl.reg_we = 1'b0;
            ctrl.mem_we = 1'b0;
            ctrl.en_ir  = 1'b0;
            ctrl.en_npc = 1'b0;
        end
    end

endmodule

// File: datapath_multicycle.sv
`include "riscv_config.svh"

module datapath_multicycle import riscv_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  ctrl_t       ctrl,
    input  mem_rsp_t    rsp,
    output mem_req_t    req,
    output logic [31:0] instr,
    output logic [31:0] pc,
    output logic [3:0]  alu_flags   // {zero, negative, carry, overflow}
);
    logic [31:0] pc_q, old_pc_q, ir_q;
    logic [31:0] a_q, b_q, alu_out_q, data_q;
    logic [31:0] rf [1:31];         // x0 is not stored
    logic [4:0]  rs1, rs2, rd;
    logic [31:0] rs1_val, rs2_val;
    logic [31:0] imm, src_a, src_b, alu_res, result, pc_next, load_val;
    logic [32:0] sum, diff;
    logic        is_sub, ovf_add, ovf_sub;
    logic [7:0]  lane_byte;

    assign rs1   = ir_q[19:15];
    assign rs2   = ir_q[24:20];
    assign rd    = ir_q[11:7];
    assign instr = ir_q;
    assign pc    = pc_q;

    assign rs1_val = (rs1 == 5'd0) ? 32'h0 : rf[rs1];
    assign rs2_val = (rs2 == 5'd0) ? 32'h0 : rf[rs2];

    always_ff @(posedge clk) begin
        if (ctrl.reg_we && rd != 5'd0) rf[rd] <= result;
    end

    always_comb begin
        case (ctrl.imm_src)
            IMM_S:   imm = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
            IMM_B:   imm = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
            IMM_J:   imm = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
            IMM_U:   imm = {ir_q[31:12], 12'h0};
            default: imm = {{20{ir_q[31]}}, ir_q[31:20]};
        endcase
    end

    function automatic logic [31:0] operand(alu_src_e sel, logic [31:0] reg_val,
                                            logic [31:0] pc_v, logic [31:0] old_pc_v,
                                            logic [31:0] imm_v);
        case (sel)
            ALU_SRC_PC:     return pc_v;
            ALU_SRC_OLD_PC: return old_pc_v;
            ALU_SRC_IMM:    return imm_v;
            ALU_SRC_FOUR:   return 32'd4;
            default:        return reg_val;
        endcase
    endfunction

    assign src_a = operand(ctrl.alu_src_a, a_q, pc_q, old_pc_q, imm);
    assign src_b = operand(ctrl.alu_src_b, b_q, pc_q, old_pc_q, imm);

    assign sum     = {1'b0, src_a} + {1'b0, src_b};
    assign diff    = {1'b0, src_a} - {1'b0, src_b};    // diff[32] is the borrow
    assign ovf_add = ~(src_a[31] ^ src_b[31]) & (src_a[31] ^ sum[31]);
    assign ovf_sub = (src_a[31] ^ src_b[31]) & (src_a[31] ^ diff[31]);
    assign is_sub  = (ctrl.alu_op == ALU_SUB) || (ctrl.alu_op == ALU_SLT);

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_res = diff[31:0];
            ALU_AND:    alu_res = src_a & src_b;
            ALU_OR:     alu_res = src_a | src_b;
            ALU_XOR:    alu_res = src_a ^ src_b;
            ALU_SLT:    alu_res = {31'h0, diff[31] ^ ovf_sub}; // signed less-than
            ALU_PASS_B: alu_res = src_b;
            default:    alu_res = sum[31:0];
        endcase
    end

    assign alu_flags = {alu_res == 32'h0, alu_res[31],
                        is_sub ? ~diff[32] : sum[32],
                        is_sub ? ovf_sub : ovf_add};

    always_comb begin
        case (ctrl.res_src)
            RES_ALU_OUT: result = alu_out_q;
            RES_MEM:     result = data_q;
            default:     result = alu_res;
        endcase
    end

    assign pc_next = ctrl.m_addr_src ? alu_out_q : result;  // redirect or pc + 4

    always_comb begin
        req.addr = ctrl.m_addr_src ? alu_out_q : pc_q;
        req.wd   = (ctrl.dt == MEM_DT_BYTE) ? {4{b_q[7:0]}} : b_q; // sb on every lane
        req.we   = ctrl.mem_we;
        req.dt   = ctrl.dt;
    end

    // lbu picks and zero-extends its lane, a misaligned word reads as zero
    assign lane_byte = rsp.rd[8*req.addr[1:0] +: 8];
    assign load_val  = (rsp.err == EALIGN) ? 32'h0 :
                       (ctrl.dt == MEM_DT_BYTE) ? {24'h0, lane_byte} : rsp.rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= `RESET_PC;
            ir_q <= 32'h0;
        end else begin
            if (ctrl.en_npc) pc_q <= pc_next;
            if (ctrl.en_ir)  ir_q <= rsp.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.en_ir) old_pc_q <= pc_q;          // pc of the instruction in ir
        a_q <= rs1_val;
        b_q <= rs2_val;
        if (!ctrl.m_addr_src) alu_out_q <= alu_res; // held while it drives the bus
        if (ctrl.m_addr_src)  data_q    <= load_val;
    end

endmodule

// File: mem.sv
`include "riscv_config.svh"

module mem import riscv_pkg::*; (
    input  logic     clk,
    input  mem_req_t req,
    output mem_rsp_t rsp
);
    localparam int AW = $clog2(`MEM_WORDS);

    logic [31:0]   mem_q [`MEM_WORDS];
    logic [AW-1:0] idx;
    logic [3:0]    be;      // byte lane enables

    assign idx = req.addr[AW+1:2];  // word index, upper bits wrap

    always_comb begin
        rsp.rd  = mem_q[idx];       // whole word even for bytes
        rsp.err = ENONE;
        if (req.dt == MEM_DT_WORD && req.addr[1:0] != 2'b00) rsp.err = EALIGN;
    end

    always_comb begin
        be = 4'b1111;
        if (req.dt == MEM_DT_BYTE) be = 4'b0001 << req.addr[1:0];
    end

    // misaligned word writes are dropped
    always_ff @(posedge clk) begin
        if (req.we && rsp.err == ENONE) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) mem_q[idx][8*i +: 8] <= req.wd[8*i +: 8];
            end
        end
    end

endmodule

// File: riscv.sv
module riscv import riscv_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        tm,         // test mode, memory owned by tm_d_*
    input  mem_req_t    tm_d_req,
    output mem_rsp_t    tm_d_rsp,
    output logic [31:0] pc,
    output logic [31:0] instr,
    output logic        reg_we,
    output logic        mem_we
);
    localparam mem_rsp_t RSP_IDLE = '{rd: 32'h0, err: ENONE};

    ctrl_t      ctrl;
    logic [3:0] alu_flags;
    mem_req_t   cpu_req, d_req;
    mem_rsp_t   cpu_rsp, d_rsp;

    controller_multicycle u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .hold      (tm),            // cpu frozen while the bench owns memory
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl)
    );

    datapath_multicycle u_dp (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl),
        .rsp       (cpu_rsp),
        .req       (cpu_req),
        .instr     (instr),
        .pc        (pc),
        .alu_flags (alu_flags)
    );

    // one memory, either side sees zeros when not selected
    assign d_req    = tm ? tm_d_req : cpu_req;
    assign cpu_rsp  = tm ? RSP_IDLE : d_rsp;
    assign tm_d_rsp = tm ? d_rsp : RSP_IDLE;

    mem u_mem (
        .clk (clk),
        .req (d_req),
        .rsp (d_rsp)
    );

    assign reg_we = ctrl.reg_we;
    assign mem_we = ctrl.mem_we;

endmodule

// File: riscv_assertions.sv
module riscv_assertions (
    input logic        clk,
    input logic        arst_n,
    input logic        tm,
    input logic [31:0] pc,
    input logic [31:0] instr,
    input logic        reg_we,
    input logic        mem_we
);
    int n_fail = 0;     // polled by the testbench

    // one write target per cycle
    we_exclusive: assert property (@(posedge clk) disable iff (!arst_n) !(reg_we && mem_we))
        else begin
            $error("reg_we and mem_we high in the same cycle");
            n_fail++;
        end

    tm_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        tm |=> $stable(pc) && $stable(instr)) // cpu frozen
        else begin
            $error("pc or instr moved while tm is high");
            n_fail++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned");
            n_fail++;
        end

endmodule

bind riscv riscv_assertions u_riscv_assertions (
    .clk    (clk),
    .arst_n (arst_n),
    .tm     (tm),
    .pc     (pc),
    .instr  (instr),
    .reg_we (reg_we),
    .mem_we (mem_we)
);

// File: riscv_config.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// unified instruction and data memory, in 32-bit words
`define MEM_WORDS 256

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: riscv_pkg.sv
package riscv_pkg;

    // memory access width
    typedef enum logic {
        MEM_DT_WORD = 1'b0,
        MEM_DT_BYTE = 1'b1
    } mem_dt_e;

    // memory status
    typedef enum logic {
        ENONE  = 1'b0,
        EALIGN = 1'b1   // word access off a 4-byte boundary
    } errno_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_PASS_B      // lui
    } alu_op_e;

    // shared by both operand muxes
    typedef enum logic [2:0] {
        ALU_SRC_REG, ALU_SRC_PC, ALU_SRC_OLD_PC, ALU_SRC_IMM, ALU_SRC_FOUR
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_J, IMM_U
    } imm_src_e;

    typedef enum logic [1:0] {
        RES_ALU_OUT, RES_MEM, RES_ALU
    } res_src_e;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        alu_src_e alu_src_a;
        alu_src_e alu_src_b;
        alu_op_e  alu_op;
        imm_src_e imm_src;
        res_src_e res_src;
        mem_dt_e  dt;
        logic     en_ir;        // load ir and old pc
        logic     en_npc;       // load pc
        logic     m_addr_src;   // 0 pc, 1 alu_out
    } ctrl_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wd;
        logic        we;
        mem_dt_e     dt;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rd;
        errno_e      err;
    } mem_rsp_t;

endpackage

// File: riscv_tb.sv
`include "riscv_config.svh"

module riscv_tb import riscv_pkg::*; ();
    localparam int N_INIT     = 7;              // addi x1..x7 seed the registers
    localparam int N_RAND     = 40;             // seeds plus random body
    localparam int EPI        = N_RAND;         // first dump store
    localparam int LOOP       = N_RAND + 7;     // self-jump
    localparam int DATA_LO    = 128;
    localparam int DATA_HI    = 191;
    localparam int DUMP       = 192;            // x1..x7 land in 192..198
    localparam int RUN_CYCLES = 40 * 5 + 50;
    localparam int PAUSE_AT   = RUN_CYCLES / 2;
    localparam int MAX_CYCLES = 8 * RUN_CYCLES; // two loads, runs and readbacks, with margin
    localparam logic [11:0] F3_IMM = {3'b111, 3'b110, 3'b100, 3'b000};
    localparam logic [14:0] F3_OP  = {3'b111, 3'b110, 3'b100, 3'b010, 3'b000};

    logic        clk = 1'b0;
    logic        arst_n, tm;
    mem_req_t    tm_d_req;
    mem_rsp_t    tm_d_rsp;
    logic [31:0] pc, instr;
    logic        reg_we, mem_we;
    logic [31:0] prog [0:LOOP];
    logic [31:0] model_mem [`MEM_WORDS];    // expected memory image
    int          cycles = 0;

    riscv u_riscv (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the run took more than %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end else if (u_riscv.u_riscv_assertions.n_fail != 0) begin
            $display("A bound assertion on the CPU failed at %0t", $time);
            $display("Test FAILED");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011}; // base is always x0
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] fill(int w);
        return 32'(w) * 32'h9e37_79b9 ^ 32'h5ac3_3ca5; // every address bit matters
    endfunction

    function automatic logic [31:0] alu(logic [2:0] f3, logic sub, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {31'h0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        int         kind, tgt;
        for (int i = 0; i < N_INIT; i++) begin
            prog[i] = enc_i(12'($urandom), 5'd0, 3'b000, 5'(i + 1), 7'b0010011);
        end
        for (int i = N_INIT; i < N_RAND; i++) begin
            rd   = 5'($urandom_range(7));
            rs1  = 5'($urandom_range(7));
            rs2  = 5'($urandom_range(7));
            tgt  = $urandom_range(EPI, i + 1);      // forward only, dump at the latest
            kind = $urandom_range(9);
            case (kind)
                0, 8: begin
                    f3 = F3_OP[3 * $urandom_range(4) +: 3];
                    prog[i] = enc_r((f3 == 3'b000 && $urandom_range(1) == 1) ? 7'h20 : 7'h00,
                                    rs2, rs1, f3, rd);
                end
                1: prog[i] = {20'($urandom), rd, 7'b0110111};     // lui
                2: prog[i] = enc_i(12'(4 * $urandom_range(DATA_HI, DATA_LO)), 5'd0, 3'b010,
                                   rd, 7'b0000011);                // lw
                3: prog[i] = enc_i(12'(4 * DATA_LO + $urandom_range(255)), 5'd0, 3'b100,
                                   rd, 7'b0000011);                // lbu
                4: prog[i] = enc_s(12'(4 * $urandom_range(DATA_HI, DATA_LO)), rs2, 3'b010);
                5: prog[i] = enc_s(12'(4 * DATA_LO + $urandom_range(255)), rs2, 3'b000);
                6: prog[i] = enc_b(13'(4 * (tgt - i)), rs2, rs1, 3'($urandom_range(1)));
                7: prog[i] = enc_j(21'(4 * (tgt - i)), rd);
                default: prog[i] = enc_i(12'($urandom), rs1, F3_IMM[3 * $urandom_range(3) +: 3],
                                         rd, 7'b0010011);
            endcase
        end
        for (int r = 1; r <= 7; r++) begin
            prog[EPI + r - 1] = enc_s(12'(4 * (DUMP + r - 1)), 5'(r), 3'b010);
        end
        prog[LOOP] = enc_j(21'd0, 5'd0);   // jal x0, 0
    endtask

    // reference execution straight from the instruction encodings
    task automatic run_model();
        logic [31:0] x [32];
        logic [31:0] pc_m, w, a, b, addr, res, nxt;
        logic        wb;
        for (int r = 0; r < 32; r++) x[r] = 32'h0;
        pc_m = `RESET_PC;
        for (int step = 0; step < 1000; step++) begin
            w = model_mem[pc_m[31:2]];
            if (w == enc_j(21'd0, 5'd0)) break;
            a   = x[w[19:15]];
            b   = x[w[24:20]];
            res = 32'h0;
            wb  = 1'b1;
            nxt = pc_m + 4;
            case (w[6:0])
                7'b0010011: res = alu(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
                7'b0110011: res = alu(w[14:12], w[30], a, b);
                7'b0110111: res = {w[31:12], 12'h0};
                7'b0000011: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    res  = model_mem[addr[31:2]];
                    if (w[14:12] == 3'b100) res = {24'h0, res[8 * addr[1:0] +: 8]};
                end
                7'b0100011: begin
                    wb   = 1'b0;
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    if (w[14:12] == 3'b010) model_mem[addr[31:2]] = b;
                    else model_mem[addr[31:2]][8 * addr[1:0] +: 8] = b[7:0];
                end
                7'b1100011: begin
                    wb = 1'b0;
                    if ((a == b) != w[12]) begin
                        nxt = pc_m + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                default: begin      // jal, nothing else is generated
                    res = pc_m + 4;
                    nxt = pc_m + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
            endcase
            if (wb && w[11:7] != 5'd0) x[w[11:7]] = res;
            pc_m = nxt;
        end
    endtask

    // one test-mode access, response taken mid-cycle
    task automatic bus(input logic [31:0] a, input logic [31:0] d, input logic w_en,
                       input mem_dt_e dt_sel, output mem_rsp_t rsp);
        @(posedge clk);
        #1;
        tm_d_req = '{addr: a, wd: d, we: w_en, dt: dt_sel};
        @(negedge clk);
        rsp = tm_d_rsp;
    endtask

    task automatic load_memory();
        mem_rsp_t rsp;
        for (int w = 0; w < `MEM_WORDS; w++) model_mem[w] = fill(w);
        for (int i = 0; i <= LOOP; i++) model_mem[`RESET_PC / 4 + i] = prog[i];
        for (int w = 0; w <= DUMP + 6; w++) begin
            bus(32'(4 * w), model_mem[w], 1'b1, MEM_DT_WORD, rsp);
        end
        bus(32'h0, 32'h0, 1'b0, MEM_DT_WORD, rsp);   // last write commits here
    endtask

    task automatic reset_cpu();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic run_cpu(input bit with_pause);
        logic [31:0] loop_pc;
        loop_pc = `RESET_PC + 4 * LOOP;
        for (int n = 0; n < RUN_CYCLES + 10; n++) begin
            @(posedge clk);
            #1;
            tm = with_pause && n >= PAUSE_AT && n < PAUSE_AT + 10; // freeze mid-run
            if (n == 0) begin
                @(negedge clk);     // first fetch, still the reset state
                check(pc, `RESET_PC, "pc in the first fetch");
                check(32'(reg_we), 32'h0, "reg_we in the first fetch");
                check(32'(mem_we), 32'h0, "mem_we in the first fetch");
            end
        end
        for (int n = 0; n < 3 && pc != loop_pc; n++) begin    // wait for the fetch state
            @(posedge clk);
            #1;
        end
        tm = 1'b1;
        check(pc, loop_pc, "pc at the self-jump");
        check(instr, prog[LOOP], "instr at the self-jump");
    endtask

    task automatic check_results();
        mem_rsp_t rsp;
        for (int w = DATA_LO; w <= DUMP + 6; w++) begin
            bus(32'(4 * w), 32'h0, 1'b0, MEM_DT_WORD, rsp);
            check(rsp.rd, model_mem[w], $sformatf("memory word %0d", w));
        end
    endtask

    initial begin
        mem_rsp_t rsp;
        arst_n   = 1'b1;
        tm       = 1'b1;
        tm_d_req = '0;
        void'($urandom(32'hedd9_f79b));
        reset_cpu();
        check(pc, `RESET_PC, "pc after reset");
        build_program();
        load_memory();
        for (int i = 0; i <= LOOP; i++) begin
            bus(32'(`RESET_PC + 4 * i), 32'h0, 1'b0, MEM_DT_WORD, rsp);
            check(rsp.rd, prog[i], $sformatf("program word %0d", i));
        end
        bus(32'(4 * DATA_LO + 2), 32'hdead_beef, 1'b1, MEM_DT_WORD, rsp);
        check(32'(rsp.err), 32'(EALIGN), "misaligned test-mode write error");
        bus(32'(4 * DATA_LO), 32'h0, 1'b0, MEM_DT_WORD, rsp);
        check(rsp.rd, fill(DATA_LO), "word after dropped misaligned write");
        run_model();
        run_cpu(1'b0);
        check_results();
        reset_cpu();                // second run, paused halfway
        load_memory();
        run_model();
        run_cpu(1'b1);
        check_results();
        if (u_riscv.u_riscv_assertions.n_fail != 0) begin
            $display("Test FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build with verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module riscv_tb -f sources.f -o riscv_sim \
    && ./obj_dir/riscv_sim +verilator+error+limit+100 > sim.log 2>&1 \
    && ! grep -q "Test FAILED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: sources.f
+incdir+.
riscv_pkg.sv
controller_multicycle.sv
datapath_multicycle.sv
mem.sv
riscv.sv
riscv_assertions.sv
riscv_tb.sv
